// ==== Bender.yml ====
package:
  name: barrel_core

sources:
  - files:
      - design/rvIsaPkg.sv
      - design/barrelPkg.sv
      - design/pipeIfs.sv
      - design/threadFetch.sv
      - design/instDecode.sv
      - design/threadRegFile.sv
      - design/aluExecute.sv
      - design/storeWriteback.sv
      - design/barrelCore.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/barrelCoreTb.sv

// ==== design/aluExecute.sv ====
// Execute, Q102H
// Immediates, ALU, branch compare, next-PC select and the Q103H pipe stage
`timescale 1ns/1ps

module aluExecute
    import rvIsaPkg::*, barrelPkg::*;
(
    input  logic         QClk,
    input  logic         arstN,
    decodeExecIf.sink    dx,
    execResultIf.source  xr,
    output xlen_t        nextPcQ102H  // Back to fetch, same cycle
);

    xlen_t   immI, immS, immB, immU, immJ;
    xlen_t   aluIn1, aluIn2, aluOutQ102H, pcPlus4Q102H;
    opcode_t opcode;
    funct3_t funct3;
    logic    funct7b5;   // SUB/SRA select
    aluOp_t  aluOp;
    logic    takenQ102H;

    assign opcode   = dx.inst[6:0];
    assign funct3   = dx.inst[14:12];
    assign funct7b5 = dx.inst[30];

    ////////////////////
    // Immediates
    ////////////////////
    assign immI = {{20{dx.inst[31]}}, dx.inst[31:20]};
    assign immS = {{20{dx.inst[31]}}, dx.inst[31:25], dx.inst[11:7]};
    assign immB = {{20{dx.inst[31]}}, dx.inst[7], dx.inst[30:25], dx.inst[11:8], 1'b0};
    assign immU = {dx.inst[31:12], 12'b0};
    assign immJ = {{12{dx.inst[31]}}, dx.inst[19:12], dx.inst[20], dx.inst[30:21], 1'b0};

    // Operand select
    always_comb begin
        aluIn1 = dx.rs1Data;
        aluIn2 = dx.rs2Data;      // R-type default
        if (dx.isLui) begin
            aluIn1 = '0;
            aluIn2 = immU;
        end else if (dx.isAuipc) begin
            aluIn1 = dx.pc;
            aluIn2 = immU;
        end else if (dx.isIType) aluIn2 = immI;
        else if (dx.isStore)     aluIn2 = immS; // Address calc
    end

    // ALU control, everything outside OP/OP-IMM adds
    always_comb begin
        aluOp = AluAdd;
        if (opcode inside {OpOp, OpImm}) begin
            case (funct3)
                3'b000:  aluOp = (opcode == OpOp && funct7b5) ? AluSub : AluAdd;
                3'b001:  aluOp = AluSll;
                3'b010:  aluOp = AluSlt;
                3'b011:  aluOp = AluSltu;
                3'b100:  aluOp = AluXor;
                3'b101:  aluOp = funct7b5 ? AluSra : AluSrl;
                3'b110:  aluOp = AluOr;
                default: aluOp = AluAnd;
            endcase
        end
    end

    always_comb begin
        case (aluOp)
            AluSub:  aluOutQ102H = aluIn1 - aluIn2;
            AluSlt:  aluOutQ102H = xlen_t'($signed(aluIn1) < $signed(aluIn2));
            AluSltu: aluOutQ102H = xlen_t'(aluIn1 < aluIn2);
            AluSll:  aluOutQ102H = aluIn1 << aluIn2[4:0];
            AluSrl:  aluOutQ102H = aluIn1 >> aluIn2[4:0];
            AluSra:  aluOutQ102H = $signed(aluIn1) >>> aluIn2[4:0];
            AluXor:  aluOutQ102H = aluIn1 ^ aluIn2;
            AluOr:   aluOutQ102H = aluIn1 | aluIn2;
            AluAnd:  aluOutQ102H = aluIn1 & aluIn2;
            default: aluOutQ102H = aluIn1 + aluIn2;
        endcase
    end

    // Branch compare, always rs1 against rs2
    always_comb begin
        case (funct3)
            3'b000:  takenQ102H = (dx.rs1Data == dx.rs2Data);                  // BEQ
            3'b001:  takenQ102H = (dx.rs1Data != dx.rs2Data);                  // BNE
            3'b100:  takenQ102H = ($signed(dx.rs1Data) < $signed(dx.rs2Data));  // BLT
            3'b101:  takenQ102H = ($signed(dx.rs1Data) >= $signed(dx.rs2Data)); // BGE
            3'b110:  takenQ102H = (dx.rs1Data < dx.rs2Data);                   // BLTU
            3'b111:  takenQ102H = (dx.rs1Data >= dx.rs2Data);                  // BGEU
            default: takenQ102H = 1'b0;
        endcase
    end

    ////////////////////
    // Next PC
    ////////////////////
    assign pcPlus4Q102H = dx.pc + 32'd4;
    always_comb begin
        if (dx.isJalr)                       nextPcQ102H = {aluOutQ102H[31:1], 1'b0};
        else if (dx.isJal)                   nextPcQ102H = dx.pc + immJ;
        else if (dx.isBranch && takenQ102H)  nextPcQ102H = dx.pc + immB;
        else                                 nextPcQ102H = pcPlus4Q102H;
    end

    // Q102H -> Q103H
    always_ff @(posedge QClk) begin
        xr.aluOut  <= aluOutQ102H;
        xr.pcPlus4 <= pcPlus4Q102H;
        xr.rs2Data <= dx.rs2Data;
        xr.funct3  <= funct3;
        xr.rdPtr   <= dx.inst[11:7];
        xr.thread  <= dx.thread;
    end

    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            xr.memWr   <= 1'b0;
            xr.pcToReg <= 1'b0;
            xr.regWr   <= 1'b0;
        end else begin
            xr.memWr   <= dx.isStore;
            xr.pcToReg <= dx.isJal || dx.isJalr; // Link writes PC+4
            xr.regWr   <= dx.regWr;
        end
    end

endmodule

// ==== design/barrelCore.sv ====
// Four-thread barrel RV32 core
// Five stages Q100H to Q104H, one instruction per thread in flight
`timescale 1ns/1ps

module barrelCore
    import rvIsaPkg::*;
(
    input  logic       QClk,
    input  logic       arstN,
    // Instruction memory
    output xlen_t      pcQ100H,
    input  xlen_t      instQ101H,      // Word at pcQ100H, one cycle later
    // Data memory, store only
    output xlen_t      memAdrsQ103H,
    output xlen_t      memWrDataQ103H,
    output logic       memWrQ103H,
    output logic [3:0] memByteEnQ103H
);

    xlen_t                nextPcQ102H;
    barrelPkg::threadId_t threadQ100H;

    regReadIf    rdIf ();
    regWriteIf   wrIf ();
    decodeExecIf dxIf ();
    execResultIf xrIf ();

    threadFetch i_threadFetch (
        .QClk, .arstN, .nextPcQ102H, .pcQ100H, .threadQ100H
    );

    instDecode i_instDecode (
        .QClk, .arstN, .pcQ100H, .threadQ100H, .instQ101H, .rd(rdIf), .dx(dxIf)
    );

    threadRegFile i_threadRegFile (.QClk, .arstN, .rd(rdIf), .wr(wrIf));

    aluExecute i_aluExecute (.QClk, .arstN, .dx(dxIf), .xr(xrIf), .nextPcQ102H);

    storeWriteback i_storeWriteback (
        .QClk, .arstN, .xr(xrIf), .wr(wrIf),
        .memAdrsQ103H, .memWrDataQ103H, .memWrQ103H, .memByteEnQ103H
    );

endmodule

// ==== design/barrelPkg.sv ====
// Barrel core definitions
// Thread count, per-thread register banks, boot PCs and pipe types
package barrelPkg;

    localparam int NumThreads = 4;
    localparam int NumRegs    = 16; // Registers per thread bank

    typedef logic [NumThreads-1:0]         threadRing_t; // One-hot
    typedef logic [$clog2(NumThreads)-1:0] threadId_t;
    typedef logic [$clog2(NumRegs)-1:0]    bankPtr_t;    // rs/rd bit 4 dropped
    typedef logic [3:0]                    byteEn_t;     // One bit per store byte

    ////////////////////
    // Reset PC per thread
    ////////////////////
    // Each thread boots into its own program region
    localparam rvIsaPkg::xlen_t ThreadBootPc [NumThreads] = '{
        32'h0000_0000,
        32'h0000_0100,
        32'h0000_0200,
        32'h0000_0300
    };

endpackage

// ==== design/instDecode.sv ====
// Instruction decode, Q101H
// Opcode decode, register read request and the Q101H to Q102H pipe stage
`timescale 1ns/1ps

module instDecode
    import rvIsaPkg::*, barrelPkg::*;
(
    input  logic          QClk,
    input  logic          arstN,
    input  xlen_t         pcQ100H,
    input  threadId_t     threadQ100H,
    input  inst_t         instQ101H,   // Returned by the I-mem one cycle after the PC
    regReadIf.requester   rd,
    decodeExecIf.source   dx
);

    xlen_t     pcQ101H;
    threadId_t threadQ101H;
    logic      vldQ101H;     // Low for the slot still in flight at reset
    opcode_t   opcodeQ101H;

    // Q100H -> Q101H
    always_ff @(posedge QClk) begin
        pcQ101H     <= pcQ100H;
        threadQ101H <= threadQ100H;
    end

    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) vldQ101H <= 1'b0;
        else        vldQ101H <= 1'b1;
    end

    assign opcodeQ101H = instQ101H[6:0];

    // Source operands from this thread's bank
    assign rd.thread = threadQ101H;
    assign rd.rs1Ptr = instQ101H[19:15];
    assign rd.rs2Ptr = instQ101H[24:20];

    ////////////////////
    // Q101H -> Q102H
    ////////////////////
    always_ff @(posedge QClk) begin
        dx.pc      <= pcQ101H;
        dx.inst    <= instQ101H;
        dx.thread  <= threadQ101H;
        dx.rs1Data <= rd.rs1Data;
        dx.rs2Data <= rd.rs2Data;
    end

    // Control bits, zero for an invalid slot
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            dx.isJal    <= 1'b0;
            dx.isJalr   <= 1'b0;
            dx.isBranch <= 1'b0;
            dx.isIType  <= 1'b0;
            dx.isLui    <= 1'b0;
            dx.isAuipc  <= 1'b0;
            dx.isStore  <= 1'b0;
            dx.regWr    <= 1'b0;
        end else begin
            dx.isJal    <= vldQ101H && (opcodeQ101H == OpJal);
            dx.isJalr   <= vldQ101H && (opcodeQ101H == OpJalr);
            dx.isBranch <= vldQ101H && (opcodeQ101H == OpBranch);
            dx.isIType  <= vldQ101H && (opcodeQ101H inside {OpImm, OpJalr});
            dx.isLui    <= vldQ101H && (opcodeQ101H == OpLui);
            dx.isAuipc  <= vldQ101H && (opcodeQ101H == OpAuipc);
            dx.isStore  <= vldQ101H && (opcodeQ101H == OpStore);
            dx.regWr    <= vldQ101H && (opcodeQ101H inside
                           {OpOp, OpImm, OpLui, OpAuipc, OpJal, OpJalr});
        end
    end

endmodule

// ==== design/pipeIfs.sv ====
// Barrel core stage interfaces
// Register file read and write ports plus the Q102H and Q103H stage bundles
`timescale 1ns/1ps

// Q101H register read, same cycle answer
interface regReadIf
    import rvIsaPkg::*, barrelPkg::*;
();
    threadId_t thread;
    regPtr_t   rs1Ptr;
    regPtr_t   rs2Ptr;
    xlen_t     rs1Data;
    xlen_t     rs2Data;

    modport requester (output thread, rs1Ptr, rs2Ptr, input rs1Data, rs2Data);
    modport responder (input thread, rs1Ptr, rs2Ptr, output rs1Data, rs2Data);
endinterface

// Q104H writeback, lands at the closing edge
interface regWriteIf
    import rvIsaPkg::*, barrelPkg::*;
();
    logic      wrEn;
    threadId_t thread;
    regPtr_t   wrPtr;
    xlen_t     wrData;

    modport source (output wrEn, thread, wrPtr, wrData);
    modport sink   (input wrEn, thread, wrPtr, wrData);
endinterface

// Decode to execute, Q102H fields
interface decodeExecIf
    import rvIsaPkg::*, barrelPkg::*;
();
    xlen_t     pc;
    inst_t     inst;
    threadId_t thread;
    xlen_t     rs1Data;
    xlen_t     rs2Data;
    logic      isJal;
    logic      isJalr;
    logic      isBranch;
    logic      isIType;   // OP-IMM or JALR
    logic      isLui;
    logic      isAuipc;
    logic      isStore;
    logic      regWr;

    modport source (output pc, inst, thread, rs1Data, rs2Data, isJal, isJalr,
                    isBranch, isIType, isLui, isAuipc, isStore, regWr);
    modport sink   (input pc, inst, thread, rs1Data, rs2Data, isJal, isJalr,
                    isBranch, isIType, isLui, isAuipc, isStore, regWr);
endinterface

// Execute to store/writeback, Q103H fields
interface execResultIf
    import rvIsaPkg::*, barrelPkg::*;
();
    xlen_t     aluOut;   // Result or store address
    xlen_t     pcPlus4;  // Link value
    xlen_t     rs2Data;  // Store data
    funct3_t   funct3;
    regPtr_t   rdPtr;
    threadId_t thread;
    logic      memWr;
    logic      pcToReg;
    logic      regWr;

    modport source (output aluOut, pcPlus4, rs2Data, funct3, rdPtr, thread,
                    memWr, pcToReg, regWr);
    modport sink   (input aluOut, pcPlus4, rs2Data, funct3, rdPtr, thread,
                    memWr, pcToReg, regWr);
endinterface

// ==== design/rvIsaPkg.sv ====
// RV32I ISA definitions
// Field types, major opcodes and ALU operation codes for decode and execute
package rvIsaPkg;

    localparam int XLen = 32;

    typedef logic [XLen-1:0] xlen_t;   // Data, address or PC word
    typedef logic [31:0]     inst_t;   // Raw instruction word
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [4:0]      regPtr_t; // rs1/rs2/rd as encoded

    ////////////////////
    // Major opcodes
    ////////////////////
    localparam opcode_t OpOp     = 7'b0110011; // R-type ALU
    localparam opcode_t OpImm    = 7'b0010011; // I-type ALU
    localparam opcode_t OpLui    = 7'b0110111;
    localparam opcode_t OpAuipc  = 7'b0010111;
    localparam opcode_t OpBranch = 7'b1100011;
    localparam opcode_t OpJal    = 7'b1101111;
    localparam opcode_t OpJalr   = 7'b1100111;
    localparam opcode_t OpStore  = 7'b0100011; // SB/SH/SW

    // ALU operations, decoded in Q102H
    typedef enum logic [3:0] {
        AluAdd, AluSub, AluSlt, AluSltu, AluSll,
        AluSrl, AluSra, AluXor, AluOr, AluAnd
    } aluOp_t;

endpackage

// ==== design/storeWriteback.sv ====
// Store and writeback, Q103H and Q104H
// Drives the data-memory store port and selects the register write data
`timescale 1ns/1ps

module storeWriteback
    import rvIsaPkg::*, barrelPkg::*;
(
    input  logic       QClk,
    input  logic       arstN,
    execResultIf.sink  xr,
    regWriteIf.source  wr,
    output xlen_t      memAdrsQ103H,
    output xlen_t      memWrDataQ103H,
    output logic       memWrQ103H,
    output byteEn_t    memByteEnQ103H
);

    xlen_t aluOutQ104H;
    xlen_t pcPlus4Q104H;
    logic  pcToRegQ104H;

    // Store port, straight from Q103H
    assign memAdrsQ103H   = xr.aluOut;
    assign memWrDataQ103H = xr.rs2Data;
    assign memWrQ103H     = xr.memWr;

    always_comb begin
        case (xr.funct3[1:0])
            2'b00:   memByteEnQ103H = 4'b0001; // SB
            2'b01:   memByteEnQ103H = 4'b0011; // SH
            2'b10:   memByteEnQ103H = 4'b1111; // SW
            default: memByteEnQ103H = 4'b0000;
        endcase
    end

    ////////////////////
    // Q103H -> Q104H
    ////////////////////
    always_ff @(posedge QClk) begin
        aluOutQ104H  <= xr.aluOut;
        pcPlus4Q104H <= xr.pcPlus4;
        wr.wrPtr     <= xr.rdPtr;
        wr.thread    <= xr.thread;
    end

    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            wr.wrEn      <= 1'b0;
            pcToRegQ104H <= 1'b0;
        end else begin
            wr.wrEn      <= xr.regWr;
            pcToRegQ104H <= xr.pcToReg;
        end
    end

    assign wr.wrData = pcToRegQ104H ? pcPlus4Q104H : aluOutQ104H; // Link or ALU

    // Decode never passes a reserved store width
    storeWidthLegal : assert property (@(posedge QClk) disable iff (!arstN)
        xr.memWr |-> (xr.funct3[1:0] != 2'b11));

endmodule

// ==== design/threadFetch.sv ====
// Thread fetch, Q100H
// Rotates the one-hot thread ring and issues the selected thread's PC
`timescale 1ns/1ps

module threadFetch
    import rvIsaPkg::*, barrelPkg::*;
(
    input  logic      QClk,
    input  logic      arstN,
    input  xlen_t     nextPcQ102H, // From execute, for the thread in Q102H
    output xlen_t     pcQ100H,
    output threadId_t threadQ100H
);

    threadRing_t threadRing;      // Thread in Q100H
    threadRing_t ringQ102H;       // Thread in Q102H
    logic [1:0]  issueVld;        // Q101H, Q102H slots filled since reset
    xlen_t       threadPc [NumThreads];

    ////////////////////
    // Thread ring
    ////////////////////
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            threadRing <= threadRing_t'(1); // Thread 0 first
            issueVld   <= '0;
        end else begin
            threadRing <= {threadRing[NumThreads-2:0], threadRing[NumThreads-1]};
            issueVld   <= {issueVld[0], 1'b1};
        end
    end

    // Two slots behind Q100H
    assign ringQ102H = {threadRing[1:0], threadRing[NumThreads-1:2]};

    // Per-thread PCs, only the Q102H owner updates
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < NumThreads; i++) threadPc[i] <= ThreadBootPc[i];
        end else if (issueVld[1]) begin // Skip the empty slots after reset
            for (int i = 0; i < NumThreads; i++) begin
                if (ringQ102H[i]) threadPc[i] <= nextPcQ102H;
            end
        end
    end

    // One-hot select of the issuing thread
    always_comb begin
        pcQ100H     = threadPc[0];
        threadQ100H = '0;
        for (int i = 0; i < NumThreads; i++) begin
            if (threadRing[i]) begin
                pcQ100H     = threadPc[i];
                threadQ100H = threadId_t'(i);
            end
        end
    end

    ringOneHot : assert property (@(posedge QClk) disable iff (!arstN) $onehot(threadRing));

endmodule

// ==== design/threadRegFile.sv ====
// Per-thread register file
// Four banks of 16 words, two combinational reads and one clocked write
`timescale 1ns/1ps

module threadRegFile
    import rvIsaPkg::*, barrelPkg::*;
(
    input  logic        QClk,
    input  logic        arstN,
    regReadIf.responder rd,
    regWriteIf.sink     wr
);

    xlen_t    bank [NumThreads][NumRegs];
    bankPtr_t wrIdx;

    assign wrIdx = bankPtr_t'(wr.wrPtr); // Bit 4 unused with 16 regs

    // Write at the edge closing Q104H
    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            for (int t = 0; t < NumThreads; t++) begin
                for (int r = 0; r < NumRegs; r++) bank[t][r] <= '0;
            end
        end else if (wr.wrEn && (wrIdx != '0)) begin // x0 stays zero
            bank[wr.thread][wrIdx] <= wr.wrData;
        end
    end

    // Q101H reads
    assign rd.rs1Data = bank[rd.thread][bankPtr_t'(rd.rs1Ptr)];
    assign rd.rs2Data = bank[rd.thread][bankPtr_t'(rd.rs2Ptr)];

    // Programs may only name x0..x15
    wrPtrInBank : assert property (@(posedge QClk) disable iff (!arstN)
        wr.wrEn |-> (wr.wrPtr < NumRegs));

endmodule

// ==== filelist.f ====
+incdir+tests
design/rvIsaPkg.sv
design/barrelPkg.sv
design/pipeIfs.sv
design/threadFetch.sv
design/instDecode.sv
design/threadRegFile.sv
design/aluExecute.sv
design/storeWriteback.sv
design/barrelCore.sv
tests/barrelCoreTb.sv

// ==== tests/tbProgram.svh ====
// Thread programs and expected stores
// Builds four programs from random operands and records each store and successor PC
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

function automatic inst_t encR(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OpOp};
endfunction

function automatic inst_t encI(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                               opcode_t op);
    return {imm, 5'(rs1), f3, 5'(rd), op};
endfunction

function automatic inst_t encS(logic [11:0] imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], OpStore};
endfunction

function automatic inst_t encB(logic [12:0] imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], OpBranch};
endfunction

function automatic inst_t encJ(logic [20:0] imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), OpJal};
endfunction

// Place one word with its successor PC
task automatic put(int t, inst_t inst, xlen_t nxt);
    imem[pcWr[t][9:2]]    = inst;
    expNext[pcWr[t][9:2]] = nxt;
    pcWr[t]               = pcWr[t] + 4;
endtask

task automatic seq(int t, inst_t inst);
    put(t, inst, pcWr[t] + 4);
endtask

// Store rs2 to the next slot of the thread's region with x15 as base
task automatic store(int t, int rs2, logic [2:0] f3, xlen_t data, logic [3:0] be);
    expAdrs[t][expCnt[t]] = 32'h400 + 32'h100 * t + stOff[t];
    expData[t][expCnt[t]] = data;
    expBe[t][expCnt[t]]   = be;
    expCnt[t]++;
    seq(t, encS(12'(stOff[t]), rs2, 15, f3));
    stOff[t] += 4;
endtask

task automatic aluStore(int t, inst_t inst, xlen_t exp);
    seq(t, inst);       // Result in x3
    store(t, 3, 3'd2, exp, 4'b1111);
endtask

// Word after a taken branch must never issue
task automatic shadow(int t);
    seq(t, encS(12'h0F0, 1, 15, 3'd2));
endtask

task automatic branch(int t, logic [2:0] f3, int rs1, int rs2, logic taken, xlen_t val);
    put(t, encB(13'd8, rs2, rs1, f3), taken ? pcWr[t] + 8 : pcWr[t] + 4);
    if (taken) shadow(t);
    else       store(t, 1, 3'd2, val, 4'b1111);
endtask

task automatic buildPrograms();
    logic [11:0] a, b, c;
    logic [19:0] u;
    logic [4:0]  s;
    xlen_t       xa, xb, xc, p;
    for (int i = 0; i < 256; i++) begin
        imem[i]    = Nop;
        expNext[i] = (i + 1) * 4;
    end
    for (int t = 0; t < 4; t++) begin
        pcWr[t]   = 32'h100 * t;
        stOff[t]  = 0;
        expCnt[t] = 0;
        a = 12'($urandom);
        do b = 12'($urandom); while (b == a);
        c = 12'($urandom);
        u = 20'($urandom);
        s = 5'($urandom);
        xa = {{20{a[11]}}, a};
        xb = {{20{b[11]}}, b};
        xc = {{20{c[11]}}, c};
        // Every thread writes x1 with its own value
        seq(t, encI(12'(32'h400 + 32'h100 * t), 0, 3'd0, 15, OpImm));
        seq(t, encI(a, 0, 3'd0, 1, OpImm));
        seq(t, encI(b, 0, 3'd0, 2, OpImm));
        store(t, 1, 3'd2, xa, 4'b1111);
        case (t)
            0: begin  // Register ALU ops
                aluStore(t, encR(7'h00, 2, 1, 3'd0, 3), xa + xb);
                aluStore(t, encR(7'h20, 2, 1, 3'd0, 3), xa - xb);
                aluStore(t, encR(7'h00, 2, 1, 3'd1, 3), xa << xb[4:0]);
                aluStore(t, encR(7'h00, 2, 1, 3'd2, 3), xlen_t'($signed(xa) < $signed(xb)));
                aluStore(t, encR(7'h00, 2, 1, 3'd3, 3), xlen_t'(xa < xb));
                aluStore(t, encR(7'h00, 2, 1, 3'd4, 3), xa ^ xb);
                aluStore(t, encR(7'h00, 2, 1, 3'd5, 3), xa >> xb[4:0]);
                aluStore(t, encR(7'h20, 2, 1, 3'd5, 3), xlen_t'($signed(xa) >>> xb[4:0]));
                aluStore(t, encR(7'h00, 2, 1, 3'd6, 3), xa | xb);
                aluStore(t, encR(7'h00, 2, 1, 3'd7, 3), xa & xb);
            end
            1: begin  // Immediate ops, LUI, AUIPC
                aluStore(t, encI(c, 1, 3'd0, 3, OpImm), xa + xc);
                aluStore(t, encI(c, 1, 3'd2, 3, OpImm), xlen_t'($signed(xa) < $signed(xc)));
                aluStore(t, encI(c, 1, 3'd3, 3, OpImm), xlen_t'(xa < xc));
                aluStore(t, encI(c, 1, 3'd4, 3, OpImm), xa ^ xc);
                aluStore(t, encI(c, 1, 3'd6, 3, OpImm), xa | xc);
                aluStore(t, encI(c, 1, 3'd7, 3, OpImm), xa & xc);
                aluStore(t, encI({7'h00, s}, 1, 3'd1, 3, OpImm), xa << s);
                aluStore(t, encI({7'h00, s}, 1, 3'd5, 3, OpImm), xa >> s);
                aluStore(t, encI({7'h20, s}, 1, 3'd5, 3, OpImm), xlen_t'($signed(xa) >>> s));
                aluStore(t, {u, 5'd3, OpLui}, {u, 12'b0});
                p = pcWr[t];
                aluStore(t, {u, 5'd3, OpAuipc}, p + {u, 12'b0});
            end
            2: begin  // Each condition taken and not taken
                branch(t, 3'd0, 1, 1, 1'b1, xa);
                branch(t, 3'd0, 1, 2, 1'b0, xa);
                branch(t, 3'd1, 1, 2, 1'b1, xa);
                branch(t, 3'd1, 1, 1, 1'b0, xa);
                branch(t, 3'd4, 1, 2, $signed(xa) < $signed(xb), xa);
                branch(t, 3'd4, 2, 1, $signed(xb) < $signed(xa), xa);
                branch(t, 3'd5, 1, 2, $signed(xa) >= $signed(xb), xa);
                branch(t, 3'd5, 2, 1, $signed(xb) >= $signed(xa), xa);
                branch(t, 3'd6, 1, 2, xa < xb, xa);
                branch(t, 3'd6, 2, 1, xb < xa, xa);
                branch(t, 3'd7, 1, 2, xa >= xb, xa);
                branch(t, 3'd7, 2, 1, xb >= xa, xa);
            end
            default: begin  // Jumps, store widths, x0
                p = pcWr[t];
                put(t, encJ(21'd8, 5), p + 8);
                shadow(t);
                store(t, 5, 3'd2, p + 4, 4'b1111);
                p = pcWr[t];
                seq(t, {20'h0, 5'd6, OpAuipc});
                put(t, encI(12'd12, 6, 3'd0, 7, OpJalr), p + 12);
                shadow(t);
                store(t, 7, 3'd2, p + 8, 4'b1111);
                store(t, 1, 3'd0, xa, 4'b0001);
                store(t, 1, 3'd1, xa, 4'b0011);
                store(t, 1, 3'd2, xa, 4'b1111);
                seq(t, encI(c, 1, 3'd0, 0, OpImm));
                store(t, 0, 3'd2, '0, 4'b1111);
            end
        endcase
        store(t, 1, 3'd2, xa, 4'b1111);   // Own x1 still intact after the last test
        put(t, encJ(21'd0, 0), pcWr[t]);  // Park on a self loop
    end
endtask

`endif

// ==== tests/barrelCoreTb.sv ====
// Barrel core testbench
// Instruction memory model, store monitor and checks on PC order and store traffic
`timescale 1ns/1ps

module barrelCoreTb
    import rvIsaPkg::*;
();

    localparam int    MaxStores  = 32;
    localparam int    CycleLimit = 200;         // ~30 instructions x 4 threads, plus margin
    localparam inst_t Nop        = 32'h0000_0013; // addi x0, x0, 0

    logic       QClk;
    logic       arstN;
    xlen_t      pcQ100H;
    xlen_t      instQ101H;
    xlen_t      memAdrsQ103H;
    xlen_t      memWrDataQ103H;
    logic       memWrQ103H;
    logic [3:0] memByteEnQ103H;

    inst_t      imem    [256];                  // Word index is PC[9:2]
    xlen_t      expNext [256];                  // Successor PC of each word
    xlen_t      pcWr    [4];                    // Build pointer per thread
    int         stOff   [4];
    xlen_t      expAdrs [4][MaxStores];
    xlen_t      expData [4][MaxStores];
    logic [3:0] expBe   [4][MaxStores];
    int         expCnt  [4];
    int         seen    [4];
    int         cycles;
    int         cyc;                            // Cycles since reset release
    xlen_t      pcHist  [4];

    logic [1:0] stThread;
    int         headIdx;
    xlen_t      headAdrs, headData, expPcNow;
    logic [3:0] headBe;
    logic       allSeen;

    barrelCore i_barrelCore (
        .QClk, .arstN, .pcQ100H, .instQ101H,
        .memAdrsQ103H, .memWrDataQ103H, .memWrQ103H, .memByteEnQ103H
    );

    `include "tbProgram.svh"

    task automatic fail();
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    ////////////////////
    // Clock, reset, run
    ////////////////////
    initial begin
        QClk = 1'b0;
        forever #10 QClk = ~QClk;
    end

    initial begin
        arstN     = 1'b0;
        instQ101H = Nop;
        void'($urandom(79681));
        buildPrograms();
        repeat (8) @(posedge QClk);
        #2 arstN = 1'b1;
        wait (allSeen);
        @(posedge QClk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // I-mem answers one cycle after the PC
    always @(posedge QClk) begin
        xlen_t pcSmp;
        pcSmp = pcQ100H;
        #2 instQ101H = imem[pcSmp[9:2]];
    end

    always @(posedge QClk) begin
        cycles++;
        if (cycles >= CycleLimit) begin
            $display("Timeout after %0d cycles with stores still missing", cycles);
            fail();
        end
    end

    ////////////////////
    // Store monitor
    ////////////////////
    assign stThread = memAdrsQ103H[9:8];        // Region 0x400 + 0x100 * thread
    assign allSeen  = (seen[0] == expCnt[0]) && (seen[1] == expCnt[1]) &&
                      (seen[2] == expCnt[2]) && (seen[3] == expCnt[3]);

    always_comb begin
        headIdx  = (seen[stThread] < MaxStores) ? seen[stThread] : 0;
        headAdrs = expAdrs[stThread][headIdx];
        headData = expData[stThread][headIdx];
        headBe   = expBe[stThread][headIdx];
        expPcNow = expNext[pcHist[3][9:2]];
    end

    always_ff @(posedge QClk or negedge arstN) begin
        if (!arstN) begin
            cyc  <= 0;
            seen <= '{default: 0};
            pcHist <= '{default: '0};
        end else begin
            cyc    <= cyc + 1;
            pcHist <= '{pcQ100H, pcHist[0], pcHist[1], pcHist[2]};
            if (memWrQ103H) seen[stThread] <= seen[stThread] + 1;
        end
    end

    // Boot order 0x000, 0x100, 0x200, 0x300
    bootPc : assert property (@(posedge QClk) disable iff (!arstN)
        (cyc < 4) |-> (pcQ100H == xlen_t'(cyc * 256)))
        else begin
            $display("FAILED pcQ100H: got %h, expected %h",
                     $sampled(pcQ100H), $sampled(cyc) * 256);
            fail();
        end

    // Each thread comes back 4 cycles later with its successor PC
    nextPc : assert property (@(posedge QClk) disable iff (!arstN)
        (cyc >= 4) |-> (pcQ100H == expPcNow))
        else begin
            $display("FAILED pcQ100H: got %h, expected %h",
                     $sampled(pcQ100H), $sampled(expPcNow));
            fail();
        end

    storeKnown : assert property (@(posedge QClk) disable iff (!arstN)
        memWrQ103H |-> (seen[stThread] < expCnt[stThread]))
        else begin
            $display("Unexpected store at address %h", $sampled(memAdrsQ103H));
            fail();
        end

    storeAdrs : assert property (@(posedge QClk) disable iff (!arstN)
        memWrQ103H |-> (memAdrsQ103H == headAdrs))
        else begin
            $display("FAILED memAdrsQ103H: got %h, expected %h",
                     $sampled(memAdrsQ103H), $sampled(headAdrs));
            fail();
        end

    storeData : assert property (@(posedge QClk) disable iff (!arstN)
        memWrQ103H |-> (memWrDataQ103H == headData))
        else begin
            $display("FAILED memWrDataQ103H: got %h, expected %h",
                     $sampled(memWrDataQ103H), $sampled(headData));
            fail();
        end

    storeBe : assert property (@(posedge QClk) disable iff (!arstN)
        memWrQ103H |-> (memByteEnQ103H == headBe))
        else begin
            $display("FAILED memByteEnQ103H: got %h, expected %h",
                     $sampled(memByteEnQ103H), $sampled(headBe));
            fail();
        end

endmodule
